// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_tx_circular_buffer_66
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
verilog/tx_ring_pkg.sv
verilog/tx_wb_write_port.sv
verilog/tx_sync_ring.sv
verilog/tx_data_ring.sv
verilog/tx_block_counter.sv
verilog/tx_page_sequencer.sv
verilog/tx_block_former.sv
verilog/tx_circular_buffer_66.sv
verification/tb_tx_circular_buffer_66.sv

// File: verification/tb_tx_circular_buffer_66.sv
// Testbench for the transmit page ring: table-driven page writes, block scoreboard, status checks
module tb_tx_circular_buffer_66
   import tx_ring_pkg::*;
();

   // ----------------------------------------------------------------------
   // Test table
   // ----------------------------------------------------------------------
   localparam int num_tests  = 4;
   // Idle cycles spent watching a page that is one oword short
   localparam int short_wait = 40;

   string test_names [num_tests] = '{"single_page", "short_page", "ring_wrap", "full_status"};
   int    test_pages [num_tests] = '{1, 1, 4, 3};
   // Last page of the row misses oword 15
   bit    test_short [num_tests] = '{1'b0, 1'b1, 1'b0, 1'b1};
   // tx_ready random about half the time, otherwise always high
   bit    test_rnd   [num_tests] = '{1'b0, 1'b0, 1'b1, 1'b1};

   // DUT inputs start in their idle levels, reset held high
   logic     clk      = 1'b0;
   logic     reset    = 1'b1;
   logic     wb_cyc   = 1'b0;
   logic     wb_stb   = 1'b0;
   logic     wb_we    = 1'b0;
   wb_addr_t wb_adr   = '0;
   oword_t   wb_dat_w = '0;
   logic     tx_ready = 1'b0;
   logic     wb_ack;
   oword_t   wb_dat_r;
   block66_t tx_block;

   // Page contents by ring page, and blocks still owed by the DUT
   payload_t pay_mem [num_pages][blocks_per_page];
   sync_t    syn_mem [num_pages][blocks_per_page];
   block66_t exp_q [$];
   block66_t exp_blk;

   string    cur_name    = "reset";
   bit       ready_en    = 1'b0;
   bit       rnd_mode    = 1'b0;
   bit       mon_en      = 1'b0;
   bit       prev_data   = 1'b0;
   logic     ready_prev  = 1'b0;
   block66_t prev_block  = idle_block;
   int       blk_cnt     = 0;
   int       cycles      = 0;
   int       cycle_limit = 0;

   tx_circular_buffer_66 tx_circular_buffer_66_i (
      .clk(clk), .reset(reset),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
      .wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
      .tx_ready(tx_ready), .tx_block(tx_block)
   );

   initial begin
      forever #5 clk = ~clk;
   end

   // ----------------------------------------------------------------------
   // Helpers
   // ----------------------------------------------------------------------
   task automatic stop_run(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_value(input string name, input oword_t expected, input oword_t actual);
      if (expected !== actual) begin
         stop_run($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
      end
   endtask

   // Classic cycle: hold the request until ack is seen, then drop it
   task automatic wb_access(input logic we, input wb_addr_t adr, input oword_t wdata,
                            output oword_t rdata);
      int waited;
      waited = 0;
      @(posedge clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_w <= wdata;
      do begin
         @(posedge clk);
         waited++;
         if (waited > 8) begin
            stop_run("Wishbone ack did not arrive within 8 cycles");
         end
      end while (!wb_ack);
      rdata = wb_dat_r;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic read_status(input page_flags_t expected);
      oword_t rd;
      wb_access(1'b0, '0, '0, rd);
      check_value({cur_name, " status"}, oword_t'(expected), rd);
   endtask

   task automatic write_oword(input page_t pg, input oword_idx_t ow, input oword_t data);
      oword_t rd;
      wb_access(1'b1, {pg, ow}, data, rd);
   endtask

   task automatic fill_page(input page_t pg);
      logic [31:0] rnd;
      for (int b = 0; b < blocks_per_page; b++) begin
         rnd = $urandom;
         pay_mem[pg][b] = {$urandom, $urandom};
         syn_mem[pg][b] = rnd[0] ? 2'b01 : 2'b10;
         // Data blocks must differ from idle
         if ({pay_mem[pg][b], syn_mem[pg][b]} == idle_block) begin
            pay_mem[pg][b][payload_w-1] = ~pay_mem[pg][b][payload_w-1];
         end
      end
   endtask

   // Oword 0 packs header b at bits 2b+1..2b, oword k carries blocks 2k-2 (low) and 2k-1
   function automatic oword_t make_oword(input page_t pg, input int ow);
      oword_t w;
      w = '0;
      if (ow == 0) begin
         for (int b = 0; b < blocks_per_page; b++) begin
            w[2*b +: 2] = syn_mem[pg][b];
         end
      end else begin
         w = {pay_mem[pg][2*ow-1], pay_mem[pg][2*ow-2]};
      end
      return w;
   endfunction

   task automatic write_owords(input page_t pg, input int count);
      for (int ow = 0; ow < count; ow++) begin
         write_oword(pg, oword_idx_t'(ow), make_oword(pg, ow));
      end
   endtask

   // Block on the line is payload over header
   task automatic push_page_blocks(input page_t pg);
      for (int b = 0; b < blocks_per_page; b++) begin
         exp_q.push_back({pay_mem[pg][b], syn_mem[pg][b]});
      end
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk);
   endtask

   function automatic int run_limit();
      int ow_total;
      int blk_total;
      ow_total  = 0;
      blk_total = 0;
      for (int i = 0; i < num_tests; i++) begin
         ow_total  += test_pages[i] * owords_per_page;
         blk_total += test_pages[i] * blocks_per_page;
      end
      return ow_total * 4 + blk_total * 8 + 200;
   endfunction

   // ----------------------------------------------------------------------
   // Gearbox request, monitor and watchdog
   // ----------------------------------------------------------------------
   always @(posedge clk) begin
      logic [31:0] rnd;
      rnd = $urandom;
      if (!ready_en) begin
         tx_ready <= 1'b0;
      end else if (rnd_mode) begin
         tx_ready <= rnd[0];
      end else begin
         tx_ready <= 1'b1;
      end
   end

   // Sampled mid-cycle, one cycle after the slot it belongs to
   always @(negedge clk) begin
      if (mon_en) begin
         if (!ready_prev) begin
            check_value({cur_name, " hold"}, oword_t'(prev_block), oword_t'(tx_block));
         end else if (tx_block != idle_block) begin
            if (exp_q.size() == 0) begin
               stop_run("A data block was sent while no full page was waiting");
            end
            exp_blk = exp_q.pop_front();
            check_value(cur_name, oword_t'(exp_blk), oword_t'(tx_block));
            // With tx_ready held high a page leaves without gaps
            if (!rnd_mode && (blk_cnt % blocks_per_page) != 0 && !prev_data) begin
               stop_run("An idle block appeared inside a page with tx_ready held high");
            end
            blk_cnt++;
            prev_data = 1'b1;
         end else begin
            prev_data = 1'b0;
         end
      end
      ready_prev = tx_ready;
      prev_block = tx_block;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         stop_run($sformatf("Timeout: the run passed its limit of %0d cycles", cycle_limit));
      end
   end

   // ----------------------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------------------
   initial begin
      page_t       wr_pg;
      page_t       start_pg;
      page_t       short_pg;
      page_flags_t exp_flags;
      logic [31:0] rnd;
      int          seed_ret;
      seed_ret    = $urandom(81237);
      cycle_limit = run_limit();
      wr_pg       = '0;
      short_pg    = '0;

      repeat (4) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      mon_en = 1'b1;
      check_value(cur_name, oword_t'(idle_block), oword_t'(tx_block));
      check_value(cur_name, '0, oword_t'(wb_ack));
      read_status('0);

      for (int t = 0; t < num_tests; t++) begin
         cur_name  = test_names[t];
         rnd_mode  = test_rnd[t];
         blk_cnt   = 0;
         exp_flags = '0;
         start_pg  = wr_pg;
         // Pages fill while tx_ready is low, so their flags stay visible
         for (int p = 0; p < test_pages[t]; p++) begin
            fill_page(wr_pg);
            if (test_short[t] && p == test_pages[t] - 1) begin
               short_pg = wr_pg;
               write_owords(wr_pg, last_oword);
            end else begin
               push_page_blocks(wr_pg);
               write_owords(wr_pg, owords_per_page);
               exp_flags[wr_pg] = 1'b1;
            end
            wr_pg = wr_pg + page_t'(1);
         end
         read_status(exp_flags);
         // Overwrite attempt on a full page, original data must still go out
         if (exp_flags != '0) begin
            rnd = $urandom;
            write_oword(start_pg, rnd[3:0], {$urandom, $urandom, $urandom, $urandom});
         end
         ready_en <= 1'b1;
         wait_drain();
         if (test_short[t]) begin
            repeat (short_wait) @(posedge clk);
            read_status('0);
            push_page_blocks(short_pg);
            write_oword(short_pg, oword_idx_t'(last_oword), make_oword(short_pg, last_oword));
            wait_drain();
         end
         ready_en <= 1'b0;
         read_status('0);
      end

      $display("TEST PASS");
      $finish;
   end

endmodule

// File: verilog/tx_block_counter.sv
// Read position counter: block index within a page and page index around the ring
module tx_block_counter
   import tx_ring_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       rd_step,
   output page_t      rd_page,
   output block_idx_t rd_block,
   output logic       last_block
);

   assign last_block = (rd_block == block_idx_t'(last_block_idx));

   // ----------------------------------------------------------------------
   // Position update
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_page  <= '0;
         rd_block <= '0;
      end else if (rd_step) begin
         if (last_block) begin
            // Next page, wraps modulo the ring size
            rd_block <= '0;
            rd_page  <= rd_page + page_t'(1);
         end else begin
            rd_block <= rd_block + block_idx_t'(1);
         end
      end
   end

   // Index must stay inside the 30 blocks of a page
   a_block_range : assert property (@(posedge clk) disable iff (reset)
      rd_block <= block_idx_t'(last_block_idx));

endmodule

// File: verilog/tx_block_former.sv
// Block former: joins header and payload into a 66-bit block, idle block for empty slots
module tx_block_former
   import tx_ring_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     tx_ready,
   input  logic     slot_data,
   input  sync_t    rd_sync,
   input  payload_t rd_payload,
   output block66_t tx_block
);

   // Ring outputs hold a real block
   logic slot_valid;

   // Updated only on consumed slots, so the output holds under back-pressure
   always_ff @(posedge clk) begin
      if (reset) begin
         slot_valid <= 1'b0;
      end else if (tx_ready) begin
         slot_valid <= slot_data;
      end
   end

   // Never send zeros, idle fills the gaps
   assign tx_block = slot_valid ? {rd_payload, rd_sync} : idle_block;

endmodule

// File: verilog/tx_circular_buffer_66.sv
// Transmit page ring top: Wishbone page writes in, one 66-bit block per gearbox request out
module tx_circular_buffer_66
   import tx_ring_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     wb_cyc,
   input  logic     wb_stb,
   input  logic     wb_we,
   input  wb_addr_t wb_adr,
   input  oword_t   wb_dat_w,
   output logic     wb_ack,
   output oword_t   wb_dat_r,
   input  logic     tx_ready,
   output block66_t tx_block
);

   // Write side
   logic        sync_wren;
   logic        data_wren;
   page_t       wr_page;
   oword_idx_t  wr_oword;
   oword_t      wr_word;
   page_flags_t page_full;
   // Read side
   logic        rd_step;
   logic        slot_data;
   logic        last_block;
   logic        page_release;
   page_t       rel_page;
   page_t       rd_page;
   block_idx_t  rd_block;
   sync_t       rd_sync;
   payload_t    rd_payload;

   // ----------------------------------------------------------------------
   // Host port
   // ----------------------------------------------------------------------
   tx_wb_write_port wb_port_i (
      .clk(clk), .reset(reset),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
      .wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
      .sync_wren(sync_wren), .data_wren(data_wren),
      .wr_page(wr_page), .wr_oword(wr_oword), .wr_word(wr_word),
      .page_release(page_release), .rel_page(rel_page),
      .page_full(page_full)
   );

   // ----------------------------------------------------------------------
   // Storage, both rings share one read position
   // ----------------------------------------------------------------------
   tx_sync_ring sync_ring_i (
      .clk(clk), .sync_wren(sync_wren), .wr_page(wr_page), .wr_word(wr_word),
      .rd_step(rd_step), .rd_page(rd_page), .rd_block(rd_block),
      .rd_sync(rd_sync)
   );

   tx_data_ring data_ring_i (
      .clk(clk), .data_wren(data_wren), .wr_page(wr_page), .wr_oword(wr_oword),
      .wr_word(wr_word), .rd_step(rd_step), .rd_page(rd_page),
      .rd_block(rd_block), .rd_payload(rd_payload)
   );

   // ----------------------------------------------------------------------
   // Read control and output
   // ----------------------------------------------------------------------
   tx_block_counter counter_i (
      .clk(clk), .reset(reset), .rd_step(rd_step),
      .rd_page(rd_page), .rd_block(rd_block), .last_block(last_block)
   );

   tx_page_sequencer sequencer_i (
      .clk(clk), .reset(reset), .tx_ready(tx_ready), .page_full(page_full),
      .rd_page(rd_page), .last_block(last_block),
      .rd_step(rd_step), .slot_data(slot_data),
      .page_release(page_release), .rel_page(rel_page)
   );

   tx_block_former former_i (
      .clk(clk), .reset(reset), .tx_ready(tx_ready), .slot_data(slot_data),
      .rd_sync(rd_sync), .rd_payload(rd_payload), .tx_block(tx_block)
   );

endmodule

// File: verilog/tx_data_ring.sv
// Payload store: written one oword at a time, read one 64-bit payload per step
module tx_data_ring
   import tx_ring_pkg::*;
(
   input  logic       clk,
   input  logic       data_wren,
   input  page_t      wr_page,
   input  oword_idx_t wr_oword,
   input  oword_t     wr_word,
   input  logic       rd_step,
   input  page_t      rd_page,
   input  block_idx_t rd_block,
   output payload_t   rd_payload
);

   // Entry index is {page, oword, half}; oword 0 entries stay unused
   payload_t                      data_mem [data_entries];
   logic [$clog2(data_entries)-1:0] wr_lo;
   logic [$clog2(data_entries)-1:0] wr_hi;
   logic [$clog2(data_entries)-1:0] rd_entry;
   oword_idx_t                    rd_oword;

   assign wr_lo = {wr_page, wr_oword, 1'b0};
   assign wr_hi = {wr_page, wr_oword, 1'b1};

   // Block b lives in oword 1 + b/2, odd blocks in the upper half
   assign rd_oword = oword_idx_t'(rd_block[block_idx_w-1:1]) + oword_idx_t'(1);
   assign rd_entry = {rd_page, rd_oword, rd_block[0]};

   always_ff @(posedge clk) begin
      if (data_wren) begin
         data_mem[wr_lo] <= wr_word[payload_w-1:0];
         data_mem[wr_hi] <= wr_word[oword_w-1:payload_w];
      end
   end

   // Registered read, lines up with the sync ring output
   always_ff @(posedge clk) begin
      if (rd_step) begin
         rd_payload <= data_mem[rd_entry];
      end
   end

endmodule

// File: verilog/tx_page_sequencer.sv
// Page sequencer FSM: waits for a full page, streams it, releases it after its last block
module tx_page_sequencer
   import tx_ring_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        tx_ready,
   input  page_flags_t page_full,
   input  page_t       rd_page,
   input  logic        last_block,
   output logic        rd_step,
   output logic        slot_data,
   output logic        page_release,
   output page_t       rel_page
);

   seq_state_t state;

   // ----------------------------------------------------------------------
   // Outputs
   // ----------------------------------------------------------------------
   // A slot carries data only while sending
   assign slot_data = (state == st_send);
   // Gearbox request advances the read position
   assign rd_step   = slot_data & tx_ready;

   // Last block consumed, hand the page back to the write side
   assign page_release = rd_step & last_block;
   assign rel_page     = rd_page;

   // ----------------------------------------------------------------------
   // State register
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_wait;
      end else begin
         case (state)
            st_wait: begin
               if (page_full[rd_page]) begin
                  state <= st_send;
               end
            end
            st_send: begin
               // One idle slot follows every page
               if (page_release) begin
                  state <= st_wait;
               end
            end
            default: state <= st_wait;
         endcase
      end
   end

   // Only a page the write port marked full is ever released
   a_release : assert property (@(posedge clk) disable iff (reset)
      page_release |-> page_full[rel_page]);

endmodule

// File: verilog/tx_ring_pkg.sv
// Transmit page ring definitions: ring sizes, address and block types, idle block, FSM states
package tx_ring_pkg;

   // ----------------------------------------------------------------------
   // Ring geometry
   // ----------------------------------------------------------------------
   // Pages used in rotation
   localparam int num_pages       = 4;
   // 128-bit words per page, oword 0 carries the sync headers
   localparam int owords_per_page = 16;
   // 66-bit blocks carried by one page, two payloads per data oword
   localparam int blocks_per_page = 30;

   localparam int page_w          = $clog2(num_pages);
   localparam int oword_idx_w     = $clog2(owords_per_page);
   localparam int block_idx_w     = $clog2(blocks_per_page);
   localparam int oword_w         = 128;
   localparam int payload_w       = 64;
   localparam int sync_w          = 2;

   // All headers of one page packed into the low bits of oword 0
   localparam int sync_word_w     = sync_w * blocks_per_page;
   // Each oword splits into two payload entries
   localparam int data_entries    = num_pages * owords_per_page * 2;
   // Writing this oword completes a page
   localparam int last_oword      = owords_per_page - 1;
   localparam int last_block_idx  = blocks_per_page - 1;

   // ----------------------------------------------------------------------
   // Types
   // ----------------------------------------------------------------------
   typedef logic [page_w-1:0]             page_t;
   typedef logic [block_idx_w-1:0]        block_idx_t;
   typedef logic [oword_idx_w-1:0]        oword_idx_t;
   // Page in the upper bits, oword in the lower bits
   typedef logic [page_w+oword_idx_w-1:0] wb_addr_t;
   typedef logic [oword_w-1:0]            oword_t;
   typedef logic [payload_w-1:0]          payload_t;
   typedef logic [sync_w-1:0]             sync_t;
   // Payload on top, sync header in bits 1..0
   typedef logic [payload_w+sync_w-1:0]   block66_t;
   typedef logic [num_pages-1:0]          page_flags_t;

   // Control block, type 0x1E, eight idle characters of zero
   localparam block66_t idle_block = {56'd0, 8'h1e, 2'b10};

   typedef enum logic {st_wait, st_send} seq_state_t;

endpackage

// File: verilog/tx_sync_ring.sv
// Sync header store: one packed header word per page, read out two bits per block
module tx_sync_ring
   import tx_ring_pkg::*;
(
   input  logic       clk,
   input  logic       sync_wren,
   input  page_t      wr_page,
   input  oword_t     wr_word,
   input  logic       rd_step,
   input  page_t      rd_page,
   input  block_idx_t rd_block,
   output sync_t      rd_sync
);

   // Header i of a page sits at bits 2i+1..2i
   logic [sync_word_w-1:0] sync_mem [num_pages];
   logic [sync_word_w-1:0] rd_word;

   // ----------------------------------------------------------------------
   // Write side
   // ----------------------------------------------------------------------
   // Only the low 60 bits of oword 0 carry headers
   always_ff @(posedge clk) begin
      if (sync_wren) begin
         sync_mem[wr_page] <= wr_word[sync_word_w-1:0];
      end
   end

   // ----------------------------------------------------------------------
   // Read side
   // ----------------------------------------------------------------------
   assign rd_word = sync_mem[rd_page];

   // Registered select, steps together with the data ring
   always_ff @(posedge clk) begin
      if (rd_step) begin
         rd_sync <= rd_word[sync_w*rd_block +: sync_w];
      end
   end

endmodule

// File: verilog/tx_wb_write_port.sv
// Wishbone classic slave for page writes, per-page full flags and status reads
module tx_wb_write_port
   import tx_ring_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        wb_cyc,
   input  logic        wb_stb,
   input  logic        wb_we,
   input  wb_addr_t    wb_adr,
   input  oword_t      wb_dat_w,
   output logic        wb_ack,
   output oword_t      wb_dat_r,
   output logic        sync_wren,
   output logic        data_wren,
   output page_t       wr_page,
   output oword_idx_t  wr_oword,
   output oword_t      wr_word,
   input  logic        page_release,
   input  page_t       rel_page,
   output page_flags_t page_full
);

   logic       req;
   logic       new_req;
   logic       wr_ok;
   page_t      adr_page;
   oword_idx_t adr_oword;

   // ----------------------------------------------------------------------
   // Request decode
   // ----------------------------------------------------------------------
   assign req = wb_cyc & wb_stb;
   // Host holds the request through the ack cycle, act on the first cycle only
   assign new_req = req & ~wb_ack;
   assign {adr_page, adr_oword} = wb_adr;

   // Writes into a full page are acked but go nowhere
   assign wr_ok     = new_req & wb_we & ~page_full[adr_page];
   assign sync_wren = wr_ok & (adr_oword == '0);
   assign data_wren = wr_ok & (adr_oword != '0);

   assign wr_page  = adr_page;
   assign wr_oword = adr_oword;
   assign wr_word  = wb_dat_w;

   // Single-cycle ack, one cycle after the request
   always_ff @(posedge clk) begin
      if (reset) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= new_req;
      end
   end

   // Status word, flags zero-extended to 128 bits
   always_ff @(posedge clk) begin
      if (new_req & ~wb_we) begin
         wb_dat_r <= oword_t'(page_full);
      end
   end

   // ----------------------------------------------------------------------
   // Full flags
   // ----------------------------------------------------------------------
   // Set with the ack of the last oword, cleared when the sequencer lets go
   always_ff @(posedge clk) begin
      if (reset) begin
         page_full <= '0;
      end else begin
         if (data_wren && adr_oword == oword_idx_t'(last_oword)) begin
            page_full[adr_page] <= 1'b1;
         end
         if (page_release) begin
            page_full[rel_page] <= 1'b0;
         end
      end
   end

   // Ack is a pulse even when the host keeps stb high
   a_ack_pulse : assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack);

endmodule
